// File: hw/spi_pkg.sv
package spi_pkg;

    // Opcodes, operands and responses all share this width
    localparam int byte_width = 8;

    // Identification
    localparam logic [byte_width-1:0] opcode_chip_id = 8'hDB;
    localparam logic [byte_width-1:0] chip_id_value  = 8'h81;

    // Scratch memory access through a shared pointer

    // Operand 0 loads the pointer
    localparam logic [byte_width-1:0] opcode_scratch_select = 8'h13;

    // One byte back per slot, pointer advances at each byte boundary
    localparam logic [byte_width-1:0] opcode_scratch_read = 8'h14;

    // Every operand is stored, then the pointer steps
    localparam logic [byte_width-1:0] opcode_scratch_write = 8'h15;

    // Event counter

    // Snapshot returned LSB first
    localparam logic [byte_width-1:0] opcode_count_read  = 8'h20;
    localparam logic [byte_width-1:0] opcode_count_clear = 8'h21;

endpackage

// File: hw/spi_peripheral.sv
`timescale 1ns/100ps

module spi_peripheral (
    input  logic                           clock,
    input  logic                           rst_n,

    input  logic                           spi_select,
    input  logic                           spi_clock,
    input  logic                           spi_data,
    output logic                           spi_data_out,

    output logic [spi_pkg::byte_width-1:0] opcode,
    output logic                           opcode_valid,
    output logic [spi_pkg::byte_width-1:0] operand,
    output logic                           operand_valid,
    output logic [7:0]                     operand_count,

    input  logic [spi_pkg::byte_width-1:0] response,
    input  logic                           response_valid
);
    import spi_pkg::*;

    localparam int                     count_width = $clog2(byte_width);
    localparam logic [count_width-1:0] last_bit    = count_width'(byte_width - 1);

    logic [1:0] select_sync;    // Bit 1 is the settled value
    logic [1:0] clock_sync;
    logic [1:0] data_sync;
    logic       clock_last;
    logic       clock_rise;     // One-cycle pulses per spi_clock edge
    logic       clock_fall;
    logic       deselected;

    logic [count_width-1:0] bit_count;
    logic                   first_byte;
    logic [byte_width-1:0]  shift_in;
    logic [byte_width-1:0]  byte_in;
    logic                   byte_done;
    logic [7:0]             operand_next;

    logic [byte_width-1:0]  shift_out;
    logic                   load_pending;

    assign deselected   = select_sync[1];
    assign byte_in      = {shift_in[byte_width-2:0], data_sync[1]};
    assign byte_done    = clock_rise && !deselected && (bit_count == last_bit);
    assign spi_data_out = shift_out[byte_width-1];    // MSB first

    // Pin synchronisers and registered edge detection
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            select_sync <= 2'b11;
            clock_sync  <= '0;
            data_sync   <= '0;
            clock_last  <= 1'b0;
            clock_rise  <= 1'b0;
            clock_fall  <= 1'b0;
        end else begin
            select_sync <= {select_sync[0], spi_select};
            clock_sync  <= {clock_sync[0], spi_clock};
            data_sync   <= {data_sync[0], spi_data};
            clock_last  <= clock_sync[1];
            clock_rise  <= clock_sync[1] & ~clock_last;
            clock_fall  <= ~clock_sync[1] & clock_last;
        end
    end

    // Byte framing
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            bit_count     <= '0;
            first_byte    <= 1'b1;
            opcode_valid  <= 1'b0;
            operand_valid <= 1'b0;
            operand_next  <= '0;
            operand_count <= '0;
        end else begin
            opcode_valid  <= 1'b0;
            operand_valid <= 1'b0;
            if (deselected) begin
                bit_count    <= '0;
                first_byte   <= 1'b1;
                operand_next <= '0;
            end else if (clock_rise) begin
                bit_count <= bit_count + 1'b1;    // Wraps at the byte boundary
                if (byte_done && first_byte) begin
                    opcode_valid <= 1'b1;
                    first_byte   <= 1'b0;
                end else if (byte_done) begin
                    operand_valid <= 1'b1;
                    operand_count <= operand_next;
                    operand_next  <= operand_next + 1'b1;
                end
            end
        end
    end

    // Received data
    always_ff @(posedge clock) begin
        if (clock_rise) begin
            shift_in <= byte_in;
        end
        if (byte_done && first_byte) begin
            opcode <= byte_in;
        end else if (byte_done) begin
            operand <= byte_in;
        end
    end

    // Response path, loaded on the first falling edge after each byte
    always_ff @(posedge clock) begin
        if (!rst_n || deselected) begin
            shift_out    <= '0;
            load_pending <= 1'b0;
        end else begin
            if (byte_done) begin
                load_pending <= 1'b1;
            end else if (clock_fall) begin
                load_pending <= 1'b0;
            end

            if (clock_fall && load_pending) begin
                shift_out <= response_valid ? response : '0;    // Nobody answered
            end else if (clock_fall) begin
                shift_out <= {shift_out[byte_width-2:0], 1'b0};
            end
        end
    end

endmodule

// File: hw/control_registers.sv
`timescale 1ns/100ps

module control_registers #(
    parameter int scratch_depth = 8
) (
    input  logic                           clock,
    input  logic                           rst_n,

    input  logic [spi_pkg::byte_width-1:0] opcode,
    input  logic                           opcode_valid,
    input  logic [spi_pkg::byte_width-1:0] operand,
    input  logic                           operand_valid,
    input  logic [7:0]                     operand_count,

    output logic [spi_pkg::byte_width-1:0] response_regs,
    output logic                           response_regs_valid
);
    import spi_pkg::*;

    // Depth is a power of two so the pointer wraps by itself
    localparam int pointer_width = $clog2(scratch_depth);

    logic [byte_width-1:0]    scratch [scratch_depth];
    logic [pointer_width-1:0] pointer;
    logic [pointer_width-1:0] pointer_next;
    logic [byte_width-1:0]    active_opcode;    // Opcode of the current transaction

    assign pointer_next = pointer + 1'b1;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < scratch_depth; i++) begin
                scratch[i] <= '0;
            end
            pointer             <= '0;
            active_opcode       <= '0;
            response_regs       <= '0;
            response_regs_valid <= 1'b0;
        end else if (opcode_valid) begin
            active_opcode <= opcode;
            case (opcode)
                opcode_chip_id: begin
                    response_regs       <= chip_id_value;
                    response_regs_valid <= 1'b1;
                end
                opcode_scratch_read: begin
                    response_regs       <= scratch[pointer];
                    response_regs_valid <= 1'b1;
                end
                default: response_regs_valid <= 1'b0;    // Not ours
            endcase
        end else if (operand_valid) begin
            case (active_opcode)
                opcode_scratch_select: begin
                    if (operand_count == 8'd0) begin
                        pointer <= operand[pointer_width-1:0];
                    end
                end
                opcode_scratch_write: begin
                    scratch[pointer] <= operand;
                    pointer          <= pointer_next;
                end
                opcode_scratch_read: begin
                    // Prefetch so the next slot streams the following byte
                    response_regs <= scratch[pointer_next];
                    pointer       <= pointer_next;
                end
                default: ;
            endcase
        end
    end

endmodule

// File: hw/event_counter.sv
`timescale 1ns/100ps

module event_counter #(
    parameter int counter_width = 16
) (
    input  logic                           clock,
    input  logic                           rst_n,

    input  logic                           event_in,

    input  logic [spi_pkg::byte_width-1:0] opcode,
    input  logic                           opcode_valid,
    input  logic                           operand_valid,

    output logic [spi_pkg::byte_width-1:0] response_count,
    output logic                           response_count_valid
);
    import spi_pkg::*;

    logic [1:0]               event_sync;
    logic                     event_last;
    logic                     event_rise;
    logic [counter_width-1:0] count;
    logic [counter_width-1:0] snapshot;    // Bytes still to be returned

    assign event_rise = event_sync[1] & ~event_last;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            event_sync <= '0;
            event_last <= 1'b0;
            count      <= '0;
        end else begin
            event_sync <= {event_sync[0], event_in};
            event_last <= event_sync[1];
            if (opcode_valid && opcode == opcode_count_clear) begin
                count <= '0;
            end else if (event_rise && count != '1) begin
                count <= count + 1'b1;    // Saturates at all ones
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            response_count_valid <= 1'b0;
        end else if (opcode_valid) begin
            response_count_valid <= (opcode == opcode_count_read);
        end
    end

    // LSB goes out first, zeros once the snapshot is drained
    always_ff @(posedge clock) begin
        if (opcode_valid && opcode == opcode_count_read) begin
            response_count <= count[byte_width-1:0];
            snapshot       <= count >> byte_width;
        end else if (operand_valid && response_count_valid) begin
            response_count <= snapshot[byte_width-1:0];
            snapshot       <= snapshot >> byte_width;
        end
    end

endmodule

// File: hw/response_arbiter.sv
`timescale 1ns/100ps

module response_arbiter (
    input  logic                           clock,
    input  logic                           rst_n,

    input  logic                           opcode_valid,
    input  logic                           spi_select,

    input  logic [spi_pkg::byte_width-1:0] response_regs,
    input  logic                           response_regs_valid,
    input  logic [spi_pkg::byte_width-1:0] response_count,
    input  logic                           response_count_valid,

    output logic [spi_pkg::byte_width-1:0] response,
    output logic                           response_valid
);

    // Dropped on deselect and on every new opcode until a peer answers
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            response_valid <= 1'b0;
        end else if (spi_select || opcode_valid) begin
            response_valid <= 1'b0;
        end else begin
            response_valid <= response_regs_valid | response_count_valid;
        end
    end

    // Control registers win, otherwise the last byte is held
    always_ff @(posedge clock) begin
        if (response_regs_valid) begin
            response <= response_regs;
        end else if (response_count_valid) begin
            response <= response_count;
        end
    end

endmodule

// File: hw/spi_subsystem_top.sv
`timescale 1ns/100ps

module spi_subsystem_top #(
    parameter int scratch_depth = 8,
    parameter int counter_width = 16
) (
    input  logic clock,
    input  logic rst_n,

    input  logic spi_select,
    input  logic spi_clock,
    input  logic spi_data,
    output logic spi_data_out,

    input  logic event_in
);
    import spi_pkg::*;

    // Command stream, broadcast to every peer
    logic [byte_width-1:0] opcode;
    logic                  opcode_valid;
    logic [byte_width-1:0] operand;
    logic                  operand_valid;
    logic [7:0]            operand_count;

    // Peer answers and the arbitrated result
    logic [byte_width-1:0] response_regs;
    logic                  response_regs_valid;
    logic [byte_width-1:0] response_count;
    logic                  response_count_valid;
    logic [byte_width-1:0] response;
    logic                  response_valid;

    spi_peripheral i_spi_peripheral (
        .clock          (clock),
        .rst_n          (rst_n),
        .spi_select     (spi_select),
        .spi_clock      (spi_clock),
        .spi_data       (spi_data),
        .spi_data_out   (spi_data_out),
        .opcode         (opcode),
        .opcode_valid   (opcode_valid),
        .operand        (operand),
        .operand_valid  (operand_valid),
        .operand_count  (operand_count),
        .response       (response),
        .response_valid (response_valid)
    );

    control_registers #(
        .scratch_depth (scratch_depth)
    ) i_control_registers (
        .clock               (clock),
        .rst_n               (rst_n),
        .opcode              (opcode),
        .opcode_valid        (opcode_valid),
        .operand             (operand),
        .operand_valid       (operand_valid),
        .operand_count       (operand_count),
        .response_regs       (response_regs),
        .response_regs_valid (response_regs_valid)
    );

    event_counter #(
        .counter_width (counter_width)
    ) i_event_counter (
        .clock                (clock),
        .rst_n                (rst_n),
        .event_in             (event_in),
        .opcode               (opcode),
        .opcode_valid         (opcode_valid),
        .operand_valid        (operand_valid),
        .response_count       (response_count),
        .response_count_valid (response_count_valid)
    );

    response_arbiter i_response_arbiter (
        .clock                (clock),
        .rst_n                (rst_n),
        .opcode_valid         (opcode_valid),
        .spi_select           (spi_select),
        .response_regs        (response_regs),
        .response_regs_valid  (response_regs_valid),
        .response_count       (response_count),
        .response_count_valid (response_count_valid),
        .response             (response),
        .response_valid       (response_valid)
    );

endmodule

// File: testbench/spi_subsystem_chk.sv
`timescale 1ns/100ps

module spi_subsystem_chk (
    input logic clock,
    input logic rst_n,
    input logic spi_select,
    input logic opcode_valid,
    input logic operand_valid,
    input logic response_valid
);

    // A byte is an opcode or an operand, never both
    valid_exclusive: assert property (
        @(posedge clock) disable iff (!rst_n) !(opcode_valid && operand_valid)
    ) else $error("opcode_valid and operand_valid high together");

    opcode_single_cycle: assert property (
        @(posedge clock) disable iff (!rst_n) opcode_valid |=> !opcode_valid
    ) else $error("opcode_valid held for more than one cycle");

    // Deselect is registered in the arbiter, one cycle late
    response_idle_deselected: assert property (
        @(posedge clock) disable iff (!rst_n) spi_select |=> !response_valid
    ) else $error("response_valid high while spi_select is high");

endmodule

bind spi_peripheral spi_subsystem_chk i_peripheral_chk (
    .clock          (clock),
    .rst_n          (rst_n),
    .spi_select     (spi_select),
    .opcode_valid   (opcode_valid),
    .operand_valid  (operand_valid),
    .response_valid (response_valid)
);

bind response_arbiter spi_subsystem_chk i_arbiter_chk (
    .clock          (clock),
    .rst_n          (rst_n),
    .spi_select     (spi_select),
    .opcode_valid   (opcode_valid),
    .operand_valid  (1'b0),    // Operands never reach the arbiter
    .response_valid (response_valid)
);

// File: testbench/tb_spi_subsystem.sv
`timescale 1ns/100ps

module tb_spi_subsystem;
    import spi_pkg::*;

    localparam int scratch_depth   = 8;
    localparam int counter_width   = 16;
    localparam int spi_phase       = 6;    // Clock cycles per spi_clock phase
    localparam int watchdog_cycles = 200000;

    logic clock;
    logic rst_n;
    logic spi_select;
    logic spi_clock;
    logic spi_data;
    logic spi_data_out;
    logic event_in;

    logic [31:0] lcg_state;
    logic [7:0]  send_bytes [32];
    logic [7:0]  got_bytes [$];       // Captured by the SPI host
    logic [7:0]  expect_bytes [$];    // Predicted by the reference model
    int          compared = 0;

    // Reference model state
    logic [7:0]               model_scratch [scratch_depth];
    int                       model_pointer;
    logic [counter_width-1:0] model_count;

    spi_subsystem_top #(
        .scratch_depth (scratch_depth),
        .counter_width (counter_width)
    ) i_dut (
        .clock        (clock),
        .rst_n        (rst_n),
        .spi_select   (spi_select),
        .spi_clock    (spi_clock),
        .spi_data     (spi_data),
        .spi_data_out (spi_data_out),
        .event_in     (event_in)
    );

    always #50 clock = ~clock;

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [7:0] pick_byte();
        logic [31:0] value;
        value = next_random();
        return value[23:16];    // Upper bits are the better ones
    endfunction

    function automatic int roll_below(input int limit);
        logic [31:0] value;
        value = next_random();
        return int'(value[30:16]) % limit;
    endfunction

    // Bytes expected on spi_data_out for send_bytes[0:n_bytes-1]
    function automatic void predict_reply(input int n_bytes);
        logic [7:0] reply;
        expect_bytes.push_back(8'h00);    // Nothing loaded during the opcode
        for (int k = 1; k < n_bytes; k++) begin
            reply = 8'h00;
            case (send_bytes[0])
                opcode_chip_id: reply = chip_id_value;
                opcode_scratch_select: begin
                    if (k == 1) begin
                        model_pointer = int'(send_bytes[1]) % scratch_depth;
                    end
                end
                opcode_scratch_write: begin
                    model_scratch[model_pointer] = send_bytes[k];
                    model_pointer = (model_pointer + 1) % scratch_depth;
                end
                opcode_scratch_read: begin
                    reply = model_scratch[model_pointer];
                    model_pointer = (model_pointer + 1) % scratch_depth;
                end
                opcode_count_read: begin
                    if (k <= counter_width / 8) begin
                        reply = model_count[8*(k-1) +: 8];    // LSB first
                    end
                end
                default: ;
            endcase
            expect_bytes.push_back(reply);
        end
        if (send_bytes[0] == opcode_count_clear) begin
            model_count = '0;
        end
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clock);
    endtask

    // Mode 0 host that changes data while spi_clock is low
    task automatic spi_exchange(input int n_bytes);
        logic [7:0] captured;
        captured   = 8'h00;
        spi_select = 1'b0;
        for (int i = 0; i < n_bytes; i++) begin
            for (int b = 7; b >= 0; b--) begin
                spi_data = send_bytes[i][b];
                idle_cycles(spi_phase);
                spi_clock = 1'b1;
                captured  = {captured[6:0], spi_data_out};
                idle_cycles(spi_phase);
                spi_clock = 1'b0;
            end
            got_bytes.push_back(captured);
        end
        idle_cycles(spi_phase);
        spi_select = 1'b1;
        spi_data   = 1'b0;
        idle_cycles(4);    // Shortest deselect gap
    endtask

    task automatic send_command(input logic [7:0] op, input int n_operands);
        send_bytes[0] = op;
        for (int i = 1; i <= n_operands; i++) begin
            send_bytes[i] = pick_byte();
        end
        predict_reply(n_operands + 1);
        spi_exchange(n_operands + 1);
    endtask

    task automatic select_pointer(input logic [7:0] pointer);
        send_bytes[0] = opcode_scratch_select;
        send_bytes[1] = pointer;
        predict_reply(2);
        spi_exchange(2);
    endtask

    task automatic pulse_events(input int n);
        for (int i = 0; i < n; i++) begin
            event_in = 1'b1;
            idle_cycles(4);
            event_in = 1'b0;
            idle_cycles(4);
            if (model_count != '1) begin
                model_count = model_count + 1'b1;    // Saturating
            end
        end
    endtask

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_value(input string name, input logic [7:0] actual,
                               input logic [7:0] expected);
        if (actual !== expected) begin
            $display("mismatch %s: got 0x%h, expected 0x%h", name, actual, expected);
            abort_run();
        end
    endtask

    always @(posedge clock) begin
        if (compared < got_bytes.size()) begin
            if (compared >= expect_bytes.size()) begin
                $display("the model predicted fewer bytes than the DUT returned");
                abort_run();
            end else begin
                check_value($sformatf("spi_data_out byte %0d", compared),
                            got_bytes[compared], expect_bytes[compared]);
                compared++;
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < watchdog_cycles) begin
            @(posedge clock);
            cycles++;
        end
        $display("timeout: the test did not finish within %0d cycles", watchdog_cycles);
        abort_run();
    end

    initial begin
        logic [7:0] pointer;
        int         drain_wait;
        lcg_state     = 32'h220d;
        clock         = 1'b0;
        rst_n         = 1'b0;
        spi_select    = 1'b1;
        spi_clock     = 1'b0;
        spi_data      = 1'b0;
        event_in      = 1'b0;
        model_pointer = 0;
        model_count   = '0;
        for (int i = 0; i < scratch_depth; i++) begin
            model_scratch[i] = 8'h00;
        end
        repeat (16) @(negedge clock);
        rst_n = 1'b1;
        idle_cycles(4);

        send_command(opcode_chip_id, 1);
        send_command(opcode_count_read, 3);    // Counter starts at zero

        // Long enough to wrap the pointer
        pointer = pick_byte();
        select_pointer(pointer);
        send_command(opcode_scratch_write, scratch_depth + 2);
        select_pointer(pointer);
        send_command(opcode_scratch_read, scratch_depth + 2);

        pulse_events(roll_below(400) + 260);    // Carries into the upper count byte
        send_command(opcode_count_read, 3);
        send_command(opcode_count_clear, 0);
        send_command(opcode_count_read, 3);

        // Unowned opcodes followed by reads that prove nothing moved
        pulse_events(5);
        send_command(8'h5A, 2);
        send_command(8'h00, 0);
        select_pointer(pointer + 8'd3);
        send_command(opcode_scratch_read, scratch_depth);
        send_command(opcode_count_read, 3);

        for (int t = 0; t < 40; t++) begin
            case (roll_below(8))
                0: send_command(opcode_chip_id, roll_below(3));
                1: select_pointer(pick_byte());
                2: send_command(opcode_scratch_write, roll_below(4) + 1);
                3: send_command(opcode_scratch_read, roll_below(4) + 1);
                4: send_command(opcode_count_read, roll_below(4));
                5: send_command(opcode_count_clear, roll_below(2));
                6: send_command(8'h40 + 8'(roll_below(64)), roll_below(3));    // 40..7F unowned
                default: pulse_events(roll_below(6) + 1);
            endcase
        end

        drain_wait = 0;
        while (compared < got_bytes.size() && drain_wait < 100) begin
            @(negedge clock);
            drain_wait++;
        end
        if (compared < got_bytes.size()) begin
            $display("timeout: comparison of the returned bytes did not finish");
            abort_run();
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

// File: all.f
hw/spi_pkg.sv
hw/spi_peripheral.sv
hw/control_registers.sv
hw/event_counter.sv
hw/response_arbiter.sv
hw/spi_subsystem_top.sv
testbench/spi_subsystem_chk.sv
testbench/tb_spi_subsystem.sv

// File: Makefile
# Verilator build and run, every variable can be overridden on the command line
VERILATOR       ?= verilator
TOP             ?= tb_spi_subsystem
FILE_LIST       ?= all.f
BUILD_DIR       ?= obj_dir
LOG             ?= sim.log
VERILATOR_FLAGS ?= --binary --timing --assert -Wno-fatal
FAIL_TEXT       ?= Simulation failed
PASS_TEXT       ?= Simulation completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILE_LIST BUILD_DIR LOG VERILATOR_FLAGS"

test:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "$(PASS_TEXT)" $(LOG); then echo "FAIL: run did not complete"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
